// ==== src.f ====
logic/rv_pkg.sv
logic/id_decoder.sv
logic/id_regfile.sv
logic/id_branch_unit.sv
logic/idex_register.sv
logic/id_stage.sv
bench/id_stage_tb.sv

// ==== Makefile ====
VERILATOR := verilator
TOP       := id_stage_tb
FILELIST  := src.f
FLAGS     := --timing --assert
BUILD_DIR := obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	out="$$(./$(BUILD_DIR)/$(TOP) 2>&1)"; echo "$$out"; \
		echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(BUILD_DIR)

// ==== bench/id_stage_tb.sv ====
`timescale 1ns/1ps

module id_stage_tb;

	localparam int CYCLE_LIMIT = 2000; // well above the few hundred cycles the tests take.

	logic                clk_i;
	logic                arst_n_i;
	logic                id_stall_i;
	logic                id_flush_i;
	logic                wb_we_i;
	logic [31:0]         id_pc_i;
	logic [31:0]         id_pc_add4_i;
	logic [31:0]         id_instr_i;
	logic [31:0]         wb_data_i;
	logic [31:0]         ex_fwd_data_i;
	logic [31:0]         mem_fwd_data_i;
	logic [31:0]         wb_fwd_data_i;
	logic [4:0]          wb_addr_i;
	logic [4:0]          id_rs1_o;
	logic [4:0]          id_rs2_o;
	logic [4:0]          ex_waddr_o;
	rv_pkg::fwd_sel_e    fwd_a_sel_i;
	rv_pkg::fwd_sel_e    fwd_b_sel_i;
	logic                take_branch_o;
	logic                jump_o;
	logic                ex_we_o;
	logic                ex_bad_jump_o;
	logic                ex_bad_branch_o;
	logic                ex_break_o;
	logic                ex_syscall_o;
	logic                ex_illegal_o;
	logic [31:0]         branch_target_o;
	logic [31:0]         jump_target_o;
	logic [31:0]         ex_pc_o;
	logic [31:0]         ex_instr_o;
	logic [31:0]         ex_port_a_o;
	logic [31:0]         ex_port_b_o;
	logic [31:0]         ex_store_data_o;
	rv_pkg::alu_op_e     ex_alu_op_o;
	rv_pkg::mem_op_e     ex_mem_op_o;

	logic [31:0]         lfsr_state;
	logic [31:0]         model [32]; // expected register file contents.
	int                  cycles;

	id_stage UUT (.*);

	always #2 clk_i = ~clk_i;

	always @(posedge clk_i) begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout, the tests did not finish within %0d cycles.", CYCLE_LIMIT);
			$display("TEST FAILED");
			$fatal(1, "simulation stopped by the cycle limit");
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// fibonacci lfsr with taps 32 22 2 1, one step per bit.
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		logic        fb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			val = {val[30:0], fb};
		end
		return val;
	endfunction

	function automatic logic [31:0] sext12(input logic [11:0] imm);
		return {{20{imm[11]}}, imm};
	endfunction

	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	// value the hazard unit asked for on one operand.
	function automatic logic [31:0] select_source(input rv_pkg::fwd_sel_e sel,
			input logic [31:0] reg_val);
		case (sel)
			rv_pkg::FWD_EX:  return ex_fwd_data_i;
			rv_pkg::FWD_MEM: return mem_fwd_data_i;
			rv_pkg::FWD_WB:  return wb_fwd_data_i;
			default:         return reg_val;
		endcase
	endfunction

	function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
			input logic [31:0] b);
		case (f3)
			3'd0:    return a == b;
			3'd1:    return a != b;
			3'd4:    return $signed(a) < $signed(b);
			3'd5:    return $signed(a) >= $signed(b);
			3'd6:    return a < b;
			3'd7:    return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
		assert (got === exp) else begin
			$display("Fail at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
			$display("TEST FAILED");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic check_alu(input rv_pkg::alu_op_e op, input logic [4:0] rd,
			input logic [31:0] a, input logic [31:0] b, input string what);
		check(32'(ex_alu_op_o), 32'(op), {what, " alu op"});
		check(32'(ex_waddr_o), 32'(rd), {what, " rd"});
		check(32'(ex_we_o), 32'd1, {what, " write enable"});
		check(ex_port_a_o, a, {what, " operand a"});
		check(ex_port_b_o, b, {what, " operand b"});
	endtask

	task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
		@(negedge clk_i);
		wb_we_i   = 1'b1;
		wb_addr_i = addr;
		wb_data_i = data;
		if (addr != 5'd0)
			model[addr] = data; // x0 stays zero.
	endtask

	// new instruction after a falling edge, combinational outputs sampled 1 ns later.
	task automatic drive(input logic [31:0] instr, input logic [31:0] pc);
		@(negedge clk_i);
		id_instr_i   = instr;
		id_pc_i      = pc;
		id_pc_add4_i = pc + 32'd4;
		#1;
	endtask

	task automatic clock_in();
		@(negedge clk_i); // one rising edge has passed.
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// directed tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic reset_and_regfile();
		logic [4:0] a;
		logic [4:0] b;
		logic [4:0] rd;
		repeat (8) @(negedge clk_i);
		check(32'(ex_we_o), 32'd0, "we in reset");
		check(32'(ex_mem_op_o), 32'(rv_pkg::MEM_NONE), "mem op in reset");
		check(ex_instr_o, rv_pkg::NOP_INSTR, "instr in reset");
		check(32'({ex_break_o, ex_syscall_o, ex_illegal_o, ex_bad_jump_o, ex_bad_branch_o}),
				32'd0, "flags in reset");
		arst_n_i = 1'b1;
		for (int r = 1; r < 32; r++)
			write_reg(5'(r), rand_bits(32));
		write_reg(5'd0, 32'hdead_beef);
		@(negedge clk_i);
		wb_we_i = 1'b0;
		repeat (8) begin
			a  = 5'(rand_bits(5));
			b  = 5'(rand_bits(5));
			rd = 5'(rand_bits(5));
			drive(r_type(7'h00, b, a, 3'b000, rd), 32'h100);
			check(32'(id_rs1_o), 32'(a), "rs1 address");
			check(32'(id_rs2_o), 32'(b), "rs2 address");
			clock_in();
			check_alu(rv_pkg::ALU_ADD, rd, model[a], model[b], "add");
		end
		drive(r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd1), 32'h104);
		clock_in();
		check(ex_port_a_o, 32'd0, "x0 read a");
		check(ex_port_b_o, 32'd0, "x0 read b");
	endtask

	task automatic alu_decode();
		logic [2:0]      tab_f3 [10];
		logic            tab_alt [10];
		rv_pkg::alu_op_e tab_op [10];
		logic [11:0]     imm;
		logic [19:0]     up;
		logic [4:0]      a;
		logic [4:0]      b;
		logic [4:0]      rd;
		tab_f3  = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
		tab_alt = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
		tab_op  = '{rv_pkg::ALU_ADD, rv_pkg::ALU_SUB, rv_pkg::ALU_SLL, rv_pkg::ALU_SLT,
				rv_pkg::ALU_SLTU, rv_pkg::ALU_XOR, rv_pkg::ALU_SRL, rv_pkg::ALU_SRA,
				rv_pkg::ALU_OR, rv_pkg::ALU_AND};
		for (int k = 0; k < 10; k++) begin
			a  = 5'(rand_bits(5));
			b  = 5'(rand_bits(5));
			rd = 5'(rand_bits(5));
			drive(r_type(tab_alt[k] ? 7'h20 : 7'h00, b, a, tab_f3[k], rd), 32'h200);
			clock_in();
			check_alu(tab_op[k], rd, model[a], model[b], "r-type");
			if (k == 1)
				continue; // there is no subi.
			if (tab_f3[k] == 3'd1 || tab_f3[k] == 3'd5)
				imm = {tab_alt[k] ? 7'h20 : 7'h00, 5'(rand_bits(5))};
			else
				imm = 12'(rand_bits(12));
			drive(i_type(imm, a, tab_f3[k], rd, rv_pkg::OPC_OP_IMM), 32'h204);
			clock_in();
			check_alu(tab_op[k], rd, model[a], sext12(imm), "i-type");
		end
		up = 20'(rand_bits(20));
		rd = 5'(rand_bits(5));
		drive({up, rd, rv_pkg::OPC_LUI}, 32'h208);
		clock_in();
		check_alu(rv_pkg::ALU_ADD, rd, 32'd0, {up, 12'h000}, "lui");
		drive({up, rd, rv_pkg::OPC_AUIPC}, 32'h20c);
		clock_in();
		check_alu(rv_pkg::ALU_ADD, rd, 32'h20c, {up, 12'h000}, "auipc");
	endtask

	task automatic forwarding_and_branches();
		logic [2:0]  tab_f3 [6];
		logic [12:0] bimm;
		logic [31:0] pc;
		logic [4:0]  a;
		logic [4:0]  b;
		tab_f3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		for (int s = 0; s < 16; s++) begin
			a              = 5'(rand_bits(5));
			b              = 5'(rand_bits(5));
			ex_fwd_data_i  = rand_bits(32);
			mem_fwd_data_i = rand_bits(32);
			wb_fwd_data_i  = rand_bits(32);
			fwd_a_sel_i    = rv_pkg::fwd_sel_e'(s[1:0]);
			fwd_b_sel_i    = rv_pkg::fwd_sel_e'(s[3:2]);
			drive(r_type(7'h00, b, a, 3'b000, 5'd3), 32'h300);
			clock_in();
			check(ex_port_a_o, select_source(fwd_a_sel_i, model[a]), "forwarded a");
			check(ex_port_b_o, select_source(fwd_b_sel_i, model[b]), "forwarded b");
		end
		fwd_a_sel_i = rv_pkg::FWD_EX;
		fwd_b_sel_i = rv_pkg::FWD_MEM;
		for (int k = 0; k < 12; k++) begin
			ex_fwd_data_i  = rand_bits(32);
			mem_fwd_data_i = (k % 2 == 0) ? ex_fwd_data_i : rand_bits(32);
			bimm = {11'(rand_bits(11)), 2'b00};
			pc   = {30'(rand_bits(30)), 2'b00};
			drive(b_type(bimm, 5'd2, 5'd1, tab_f3[k / 2]), pc);
			check(32'(take_branch_o),
					32'(branch_taken(tab_f3[k / 2], ex_fwd_data_i, mem_fwd_data_i)),
					"branch decision");
			check(branch_target_o, pc + {{19{bimm[12]}}, bimm}, "branch target");
			check(32'(jump_o), 32'd0, "jump on a branch");
			clock_in();
		end
		fwd_a_sel_i = rv_pkg::FWD_REG;
		fwd_b_sel_i = rv_pkg::FWD_REG;
	endtask

	task automatic jumps();
		logic [20:0] jimm;
		logic [11:0] imm;
		logic [31:0] pc;
		logic [31:0] target;
		logic [4:0]  rd;
		pc   = {30'(rand_bits(30)), 2'b00};
		jimm = {19'(rand_bits(19)), 2'b00};
		rd   = 5'(rand_bits(5));
		drive(j_type(jimm, rd), pc);
		check(32'(jump_o), 32'd1, "jal jump");
		check(jump_target_o, pc + {{11{jimm[20]}}, jimm}, "jal target");
		clock_in();
		check_alu(rv_pkg::ALU_ADD, rd, pc + 32'd4, 32'd0, "jal link");
		check(32'(ex_bad_jump_o), 32'd0, "jal aligned target");
		fwd_a_sel_i = rv_pkg::FWD_EX;
		repeat (4) begin
			ex_fwd_data_i = rand_bits(32);
			imm           = 12'(rand_bits(12));
			target        = (ex_fwd_data_i + sext12(imm)) & ~32'd1;
			drive(i_type(imm, 5'd7, 3'b000, rd, rv_pkg::OPC_JALR), pc);
			check(32'(jump_o), 32'd1, "jalr jump");
			check(jump_target_o, target, "jalr target");
			clock_in();
			check_alu(rv_pkg::ALU_ADD, rd, pc + 32'd4, 32'd0, "jalr link");
			check(32'(ex_bad_jump_o), 32'(target[1]), "jalr misaligned flag");
		end
		drive(j_type(21'd6, rd), pc);
		clock_in();
		check(32'(ex_bad_jump_o), 32'd1, "jal misaligned flag");
		fwd_b_sel_i = rv_pkg::FWD_EX; // equal operands, beq taken.
		drive(b_type(13'd6, 5'd2, 5'd1, 3'b000), pc);
		check(32'(take_branch_o), 32'd1, "beq taken");
		clock_in();
		check(32'(ex_bad_branch_o), 32'd1, "branch misaligned flag");
		fwd_a_sel_i = rv_pkg::FWD_REG;
		fwd_b_sel_i = rv_pkg::FWD_REG;
	endtask

	task automatic memory_and_system();
		logic [2:0]      ld_f3 [5];
		rv_pkg::mem_op_e ld_op [5];
		rv_pkg::mem_op_e st_op [3];
		logic [11:0]     imm;
		logic [4:0]      a;
		logic [4:0]      rd;
		ld_f3 = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
		ld_op = '{rv_pkg::MEM_LB, rv_pkg::MEM_LH, rv_pkg::MEM_LW, rv_pkg::MEM_LBU,
				rv_pkg::MEM_LHU};
		st_op = '{rv_pkg::MEM_SB, rv_pkg::MEM_SH, rv_pkg::MEM_SW};
		for (int k = 0; k < 5; k++) begin
			a   = 5'(rand_bits(5));
			rd  = 5'(rand_bits(5));
			imm = 12'(rand_bits(12));
			drive(i_type(imm, a, ld_f3[k], rd, rv_pkg::OPC_LOAD), 32'h500);
			clock_in();
			check(32'(ex_mem_op_o), 32'(ld_op[k]), "load mem op");
			check_alu(rv_pkg::ALU_ADD, rd, model[a], sext12(imm), "load");
		end
		fwd_b_sel_i = rv_pkg::FWD_WB;
		for (int k = 0; k < 3; k++) begin
			wb_fwd_data_i = rand_bits(32);
			a             = 5'(rand_bits(5));
			imm           = 12'(rand_bits(12));
			drive(s_type(imm, 5'd4, a, 3'(k)), 32'h504);
			clock_in();
			check(32'(ex_mem_op_o), 32'(st_op[k]), "store mem op");
			check(32'(ex_we_o), 32'd0, "store write enable");
			check(ex_port_a_o, model[a], "store base");
			check(ex_port_b_o, sext12(imm), "store offset");
			check(ex_store_data_o, wb_fwd_data_i, "store data");
		end
		fwd_b_sel_i = rv_pkg::FWD_REG;
		drive(32'h0000_0073, 32'h508);
		clock_in();
		check(32'({ex_syscall_o, ex_break_o, ex_illegal_o}), 32'(3'b100), "ecall flags");
		drive(32'h0010_0073, 32'h50c);
		clock_in();
		check(32'({ex_syscall_o, ex_break_o, ex_illegal_o}), 32'(3'b010), "ebreak flags");
		drive(32'hffff_ffff, 32'h510);
		clock_in();
		check(32'({ex_syscall_o, ex_break_o, ex_illegal_o}), 32'(3'b001), "illegal flags");
		check(32'(ex_we_o), 32'd0, "illegal write enable");
	endtask

	task automatic stall_and_flush();
		logic [31:0] instr_a;
		logic [31:0] instr_b;
		instr_a = i_type(12'h010, 5'd5, 3'b010, 5'd6, rv_pkg::OPC_LOAD);
		instr_b = r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd9);
		drive(instr_a, 32'h600);
		clock_in();
		check(ex_instr_o, instr_a, "instr before stall");
		check(ex_port_a_o, model[5], "operand before stall");
		id_stall_i = 1'b1;
		drive(instr_b, 32'h604);
		clock_in();
		check(ex_instr_o, instr_a, "instr held by stall");
		check(ex_pc_o, 32'h600, "pc held by stall");
		check(ex_port_a_o, model[5], "operand held by stall");
		check(32'(ex_mem_op_o), 32'(rv_pkg::MEM_LW), "mem op held by stall");
		id_flush_i = 1'b1;
		clock_in();
		check(ex_instr_o, instr_a, "stall over flush");
		check(32'(ex_we_o), 32'd1, "we held over flush");
		id_stall_i = 1'b0;
		clock_in();
		check(ex_instr_o, rv_pkg::NOP_INSTR, "bubble instr");
		check(32'(ex_we_o), 32'd0, "bubble we");
		check(32'(ex_mem_op_o), 32'(rv_pkg::MEM_NONE), "bubble mem op");
		check(32'(ex_alu_op_o), 32'(rv_pkg::ALU_ADD), "bubble alu op");
		check(32'({ex_break_o, ex_syscall_o, ex_illegal_o, ex_bad_jump_o, ex_bad_branch_o}),
				32'd0, "bubble flags");
		id_flush_i = 1'b0;
		clock_in();
		check(ex_instr_o, instr_b, "instr after flush");
		check(32'(ex_alu_op_o), 32'(rv_pkg::ALU_SUB), "alu op after flush");
	endtask

	initial begin
		clk_i          = 1'b0;
		arst_n_i       = 1'b0;
		id_stall_i     = 1'b0;
		id_flush_i     = 1'b0;
		id_pc_i        = 32'd0;
		id_pc_add4_i   = 32'd4;
		id_instr_i     = rv_pkg::NOP_INSTR;
		wb_we_i        = 1'b0;
		wb_addr_i      = 5'd0;
		wb_data_i      = 32'd0;
		ex_fwd_data_i  = 32'd0;
		mem_fwd_data_i = 32'd0;
		wb_fwd_data_i  = 32'd0;
		fwd_a_sel_i    = rv_pkg::FWD_REG;
		fwd_b_sel_i    = rv_pkg::FWD_REG;
		lfsr_state     = 32'h351a;
		cycles         = 0;
		model[0]       = 32'd0;
		reset_and_regfile();
		alu_decode();
		forwarding_and_branches();
		jumps();
		memory_and_system();
		stall_and_flush();
		$display("TEST OK");
		$finish;
	end

endmodule

// ==== logic/id_stage.sv ====
`timescale 1ns/1ps

module id_stage (
	input  logic                          clk_i,
	input  logic                          arst_n_i,
	input  logic                          id_stall_i,
	input  logic                          id_flush_i,
	input  logic [rv_pkg::XLEN-1:0]       id_pc_i,
	input  logic [rv_pkg::XLEN-1:0]       id_pc_add4_i,
	input  logic [rv_pkg::XLEN-1:0]       id_instr_i,
	input  logic [rv_pkg::XLEN-1:0]       wb_data_i,
	input  logic [rv_pkg::REG_ADDR_W-1:0] wb_addr_i,
	input  logic                          wb_we_i,
	input  logic [rv_pkg::XLEN-1:0]       ex_fwd_data_i,
	input  logic [rv_pkg::XLEN-1:0]       mem_fwd_data_i,
	input  logic [rv_pkg::XLEN-1:0]       wb_fwd_data_i,
	input  rv_pkg::fwd_sel_e              fwd_a_sel_i,
	input  rv_pkg::fwd_sel_e              fwd_b_sel_i,
	output logic [rv_pkg::REG_ADDR_W-1:0] id_rs1_o,
	output logic [rv_pkg::REG_ADDR_W-1:0] id_rs2_o,
	output logic [rv_pkg::XLEN-1:0]       branch_target_o,
	output logic [rv_pkg::XLEN-1:0]       jump_target_o,
	output logic                          take_branch_o,
	output logic                          jump_o,
	output logic [rv_pkg::XLEN-1:0]       ex_pc_o,
	output logic [rv_pkg::XLEN-1:0]       ex_instr_o,
	output logic [rv_pkg::XLEN-1:0]       ex_port_a_o,
	output logic [rv_pkg::XLEN-1:0]       ex_port_b_o,
	output rv_pkg::alu_op_e               ex_alu_op_o,
	output logic [rv_pkg::REG_ADDR_W-1:0] ex_waddr_o,
	output logic                          ex_we_o,
	output rv_pkg::mem_op_e               ex_mem_op_o,
	output logic [rv_pkg::XLEN-1:0]       ex_store_data_o,
	output logic                          ex_bad_jump_o,
	output logic                          ex_bad_branch_o,
	output logic                          ex_break_o,
	output logic                          ex_syscall_o,
	output logic                          ex_illegal_o
);

	logic [rv_pkg::REG_ADDR_W-1:0] rd;
	logic [rv_pkg::XLEN-1:0]       rs1_data;
	logic [rv_pkg::XLEN-1:0]       rs2_data;
	logic [rv_pkg::XLEN-1:0]       rs1_fwd;
	logic [rv_pkg::XLEN-1:0]       rs2_fwd;
	logic [rv_pkg::XLEN-1:0]       imm;
	logic [rv_pkg::XLEN-1:0]       port_a;
	logic [rv_pkg::XLEN-1:0]       port_b;
	logic                          we;
	logic                          jalr;
	logic                          break_op;
	logic                          syscall;
	logic                          illegal;
	logic                          bad_jump;
	logic                          bad_branch;
	rv_pkg::alu_op_e               alu_op;
	rv_pkg::cmp_op_e               cmp_op;
	rv_pkg::mem_op_e               mem_op;
	rv_pkg::opa_sel_e              opa_sel;
	rv_pkg::opb_sel_e              opb_sel;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// forwarding and operand muxes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		case (fwd_a_sel_i)
			rv_pkg::FWD_EX:  rs1_fwd = ex_fwd_data_i;
			rv_pkg::FWD_MEM: rs1_fwd = mem_fwd_data_i;
			rv_pkg::FWD_WB:  rs1_fwd = wb_fwd_data_i;
			default:         rs1_fwd = rs1_data;
		endcase
		case (fwd_b_sel_i)
			rv_pkg::FWD_EX:  rs2_fwd = ex_fwd_data_i;
			rv_pkg::FWD_MEM: rs2_fwd = mem_fwd_data_i;
			rv_pkg::FWD_WB:  rs2_fwd = wb_fwd_data_i;
			default:         rs2_fwd = rs2_data;
		endcase
		case (opa_sel)
			rv_pkg::OPA_PC:   port_a = id_pc_i;
			rv_pkg::OPA_PC4:  port_a = id_pc_add4_i; // link value.
			rv_pkg::OPA_ZERO: port_a = '0;
			default:          port_a = rs1_fwd;
		endcase
		case (opb_sel)
			rv_pkg::OPB_RS2: port_b = rs2_fwd;
			rv_pkg::OPB_IMM: port_b = imm;
			default:         port_b = '0;
		endcase
	end

	id_decoder DECODER (
		.instr_i(id_instr_i), .rs1_o(id_rs1_o), .rs2_o(id_rs2_o), .rd_o(rd),
		.we_o(we), .imm_o(imm), .alu_op_o(alu_op), .cmp_op_o(cmp_op),
		.mem_op_o(mem_op), .opa_sel_o(opa_sel), .opb_sel_o(opb_sel),
		.jump_o(jump_o), .jalr_o(jalr), .break_o(break_op),
		.syscall_o(syscall), .illegal_o(illegal)
	);

	id_regfile REGFILE (
		.clk_i(clk_i), .raddr_a_i(id_rs1_o), .raddr_b_i(id_rs2_o),
		.waddr_i(wb_addr_i), .wdata_i(wb_data_i), .we_i(wb_we_i),
		.rdata_a_o(rs1_data), .rdata_b_o(rs2_data)
	);

	id_branch_unit BRANCH (
		.cmp_op_i(cmp_op), .rs1_data_i(rs1_fwd), .rs2_data_i(rs2_fwd),
		.pc_i(id_pc_i), .imm_i(imm), .jump_i(jump_o), .jalr_i(jalr),
		.take_branch_o(take_branch_o), .branch_target_o(branch_target_o),
		.jump_target_o(jump_target_o), .bad_jump_o(bad_jump),
		.bad_branch_o(bad_branch)
	);

	idex_register ID_EX (
		.clk_i(clk_i), .arst_n_i(arst_n_i), .stall_i(id_stall_i), .flush_i(id_flush_i),
		.id_pc_i(id_pc_i), .id_instr_i(id_instr_i), .id_port_a_i(port_a),
		.id_port_b_i(port_b), .id_alu_op_i(alu_op), .id_waddr_i(rd), .id_we_i(we),
		.id_mem_op_i(mem_op), .id_store_data_i(rs2_fwd), .id_bad_jump_i(bad_jump),
		.id_bad_branch_i(bad_branch), .id_break_i(break_op), .id_syscall_i(syscall),
		.id_illegal_i(illegal),
		.ex_pc_o(ex_pc_o), .ex_instr_o(ex_instr_o), .ex_port_a_o(ex_port_a_o),
		.ex_port_b_o(ex_port_b_o), .ex_alu_op_o(ex_alu_op_o), .ex_waddr_o(ex_waddr_o),
		.ex_we_o(ex_we_o), .ex_mem_op_o(ex_mem_op_o), .ex_store_data_o(ex_store_data_o),
		.ex_bad_jump_o(ex_bad_jump_o), .ex_bad_branch_o(ex_bad_branch_o),
		.ex_break_o(ex_break_o), .ex_syscall_o(ex_syscall_o), .ex_illegal_o(ex_illegal_o)
	);

endmodule

// ==== logic/idex_register.sv ====
`timescale 1ns/1ps

module idex_register (
	input  logic                          clk_i,
	input  logic                          arst_n_i,
	input  logic                          stall_i,
	input  logic                          flush_i,
	input  logic [rv_pkg::XLEN-1:0]       id_pc_i,
	input  logic [rv_pkg::XLEN-1:0]       id_instr_i,
	input  logic [rv_pkg::XLEN-1:0]       id_port_a_i,
	input  logic [rv_pkg::XLEN-1:0]       id_port_b_i,
	input  rv_pkg::alu_op_e               id_alu_op_i,
	input  logic [rv_pkg::REG_ADDR_W-1:0] id_waddr_i,
	input  logic                          id_we_i,
	input  rv_pkg::mem_op_e               id_mem_op_i,
	input  logic [rv_pkg::XLEN-1:0]       id_store_data_i,
	input  logic                          id_bad_jump_i,
	input  logic                          id_bad_branch_i,
	input  logic                          id_break_i,
	input  logic                          id_syscall_i,
	input  logic                          id_illegal_i,
	output logic [rv_pkg::XLEN-1:0]       ex_pc_o,
	output logic [rv_pkg::XLEN-1:0]       ex_instr_o,
	output logic [rv_pkg::XLEN-1:0]       ex_port_a_o,
	output logic [rv_pkg::XLEN-1:0]       ex_port_b_o,
	output rv_pkg::alu_op_e               ex_alu_op_o,
	output logic [rv_pkg::REG_ADDR_W-1:0] ex_waddr_o,
	output logic                          ex_we_o,
	output rv_pkg::mem_op_e               ex_mem_op_o,
	output logic [rv_pkg::XLEN-1:0]       ex_store_data_o,
	output logic                          ex_bad_jump_o,
	output logic                          ex_bad_branch_o,
	output logic                          ex_break_o,
	output logic                          ex_syscall_o,
	output logic                          ex_illegal_o
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// control, stall beats flush
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i || (flush_i && !stall_i)) begin // reset and bubble match.
			ex_instr_o      <= rv_pkg::NOP_INSTR;
			ex_alu_op_o     <= rv_pkg::ALU_ADD;
			ex_we_o         <= 1'b0;
			ex_mem_op_o     <= rv_pkg::MEM_NONE;
			ex_bad_jump_o   <= 1'b0;
			ex_bad_branch_o <= 1'b0;
			ex_break_o      <= 1'b0;
			ex_syscall_o    <= 1'b0;
			ex_illegal_o    <= 1'b0;
		end else if (!stall_i) begin
			ex_instr_o      <= id_instr_i;
			ex_alu_op_o     <= id_alu_op_i;
			ex_we_o         <= id_we_i;
			ex_mem_op_o     <= id_mem_op_i;
			ex_bad_jump_o   <= id_bad_jump_i;
			ex_bad_branch_o <= id_bad_branch_i;
			ex_break_o      <= id_break_i;
			ex_syscall_o    <= id_syscall_i;
			ex_illegal_o    <= id_illegal_i;
		end
	end

	// payload, meaningless inside a bubble.
	always_ff @(posedge clk_i) begin
		if (!stall_i) begin
			ex_pc_o         <= id_pc_i;
			ex_port_a_o     <= id_port_a_i;
			ex_port_b_o     <= id_port_b_i;
			ex_waddr_o      <= id_waddr_i;
			ex_store_data_o <= id_store_data_i;
		end
	end

	a_flush_kills_we: assert property (@(posedge clk_i) disable iff (!arst_n_i)
			(flush_i && !stall_i) |=> !ex_we_o);

endmodule

// ==== logic/id_branch_unit.sv ====
`timescale 1ns/1ps

module id_branch_unit (
	input  rv_pkg::cmp_op_e         cmp_op_i,
	input  logic [rv_pkg::XLEN-1:0] rs1_data_i,
	input  logic [rv_pkg::XLEN-1:0] rs2_data_i,
	input  logic [rv_pkg::XLEN-1:0] pc_i,
	input  logic [rv_pkg::XLEN-1:0] imm_i,
	input  logic                    jump_i,
	input  logic                    jalr_i,
	output logic                    take_branch_o,
	output logic [rv_pkg::XLEN-1:0] branch_target_o,
	output logic [rv_pkg::XLEN-1:0] jump_target_o,
	output logic                    bad_jump_o,
	output logic                    bad_branch_o
);

	logic [rv_pkg::XLEN-1:0] jalr_sum;
	logic                    eq;
	logic                    lt;
	logic                    ltu;

	assign eq  = (rs1_data_i == rs2_data_i);
	assign lt  = ($signed(rs1_data_i) < $signed(rs2_data_i));
	assign ltu = (rs1_data_i < rs2_data_i);

	always_comb begin
		case (cmp_op_i)
			rv_pkg::CMP_EQ:  take_branch_o = eq;
			rv_pkg::CMP_NE:  take_branch_o = !eq;
			rv_pkg::CMP_LT:  take_branch_o = lt;
			rv_pkg::CMP_GE:  take_branch_o = !lt;
			rv_pkg::CMP_LTU: take_branch_o = ltu;
			rv_pkg::CMP_GEU: take_branch_o = !ltu;
			default:         take_branch_o = 1'b0;
		endcase
	end

	assign branch_target_o = pc_i + imm_i;
	assign jalr_sum        = rs1_data_i + imm_i;
	assign jump_target_o   = jalr_i ? {jalr_sum[rv_pkg::XLEN-1:1], 1'b0} : branch_target_o;

	// targets must be word aligned, no compressed instructions.
	assign bad_jump_o   = jump_i && (jump_target_o[1:0] != 2'b00);
	assign bad_branch_o = take_branch_o && (branch_target_o[1:0] != 2'b00);

endmodule

// ==== logic/id_regfile.sv ====
`timescale 1ns/1ps

module id_regfile (
	input  logic                          clk_i,
	input  logic [rv_pkg::REG_ADDR_W-1:0] raddr_a_i,
	input  logic [rv_pkg::REG_ADDR_W-1:0] raddr_b_i,
	input  logic [rv_pkg::REG_ADDR_W-1:0] waddr_i,
	input  logic [rv_pkg::XLEN-1:0]       wdata_i,
	input  logic                          we_i,
	output logic [rv_pkg::XLEN-1:0]       rdata_a_o,
	output logic [rv_pkg::XLEN-1:0]       rdata_b_o
);

	localparam int DEPTH = 2 ** rv_pkg::REG_ADDR_W;

	logic [rv_pkg::XLEN-1:0] regs [DEPTH];

	always_ff @(posedge clk_i) begin
		if (we_i && waddr_i != '0) begin
			regs[waddr_i] <= wdata_i; // x0 is never written.
		end
	end

	// asynchronous reads, x0 reads as zero.
	assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
	assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

endmodule

// ==== logic/id_decoder.sv ====
`timescale 1ns/1ps

module id_decoder (
	input  logic [rv_pkg::XLEN-1:0]       instr_i,
	output logic [rv_pkg::REG_ADDR_W-1:0] rs1_o,
	output logic [rv_pkg::REG_ADDR_W-1:0] rs2_o,
	output logic [rv_pkg::REG_ADDR_W-1:0] rd_o,
	output logic                          we_o,
	output logic [rv_pkg::XLEN-1:0]       imm_o,
	output rv_pkg::alu_op_e               alu_op_o,
	output rv_pkg::cmp_op_e               cmp_op_o,
	output rv_pkg::mem_op_e               mem_op_o,
	output rv_pkg::opa_sel_e              opa_sel_o,
	output rv_pkg::opb_sel_e              opb_sel_o,
	output logic                          jump_o,
	output logic                          jalr_o,
	output logic                          break_o,
	output logic                          syscall_o,
	output logic                          illegal_o
);

	rv_pkg::opcode_e          opcode;
	logic [2:0]               funct3;
	logic [6:0]               funct7;
	logic [rv_pkg::XLEN-1:0]  imm_i_type;
	logic [rv_pkg::XLEN-1:0]  imm_s_type;
	logic [rv_pkg::XLEN-1:0]  imm_b_type;
	logic [rv_pkg::XLEN-1:0]  imm_u_type;
	logic [rv_pkg::XLEN-1:0]  imm_j_type;

	// base alu op from funct3, alt selects sub and sra.
	function automatic rv_pkg::alu_op_e f3_alu(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  return alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
			3'b001:  return rv_pkg::ALU_SLL;
			3'b010:  return rv_pkg::ALU_SLT;
			3'b011:  return rv_pkg::ALU_SLTU;
			3'b100:  return rv_pkg::ALU_XOR;
			3'b101:  return alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
			3'b110:  return rv_pkg::ALU_OR;
			default: return rv_pkg::ALU_AND;
		endcase
	endfunction

	assign opcode = rv_pkg::opcode_e'(instr_i[6:0]);
	assign funct3 = instr_i[14:12];
	assign funct7 = instr_i[31:25];
	assign rs1_o  = instr_i[19:15];
	assign rs2_o  = instr_i[24:20];
	assign rd_o   = instr_i[11:7];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// immediates, all sign extended from bit 31
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
	assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
	assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
			instr_i[11:8], 1'b0};
	assign imm_u_type = {instr_i[31:12], 12'h000};
	assign imm_j_type = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
			instr_i[30:21], 1'b0};

	always_comb begin
		we_o      = 1'b0;
		imm_o     = imm_i_type;
		alu_op_o  = rv_pkg::ALU_ADD;
		cmp_op_o  = rv_pkg::CMP_NONE;
		mem_op_o  = rv_pkg::MEM_NONE;
		opa_sel_o = rv_pkg::OPA_RS1;
		opb_sel_o = rv_pkg::OPB_IMM;
		jump_o    = 1'b0;
		jalr_o    = 1'b0;
		break_o   = 1'b0;
		syscall_o = 1'b0;
		illegal_o = 1'b0;
		case (opcode)
			rv_pkg::OPC_LUI: begin
				we_o      = 1'b1;
				imm_o     = imm_u_type;
				opa_sel_o = rv_pkg::OPA_ZERO;
			end
			rv_pkg::OPC_AUIPC: begin
				we_o      = 1'b1;
				imm_o     = imm_u_type;
				opa_sel_o = rv_pkg::OPA_PC;
			end
			rv_pkg::OPC_JAL, rv_pkg::OPC_JALR: begin // link value is pc+4.
				we_o      = 1'b1;
				imm_o     = (opcode == rv_pkg::OPC_JAL) ? imm_j_type : imm_i_type;
				opa_sel_o = rv_pkg::OPA_PC4;
				opb_sel_o = rv_pkg::OPB_ZERO;
				jump_o    = 1'b1;
				jalr_o    = (opcode == rv_pkg::OPC_JALR);
				illegal_o = (opcode == rv_pkg::OPC_JALR) && (funct3 != 3'b000);
			end
			rv_pkg::OPC_BRANCH: begin
				imm_o = imm_b_type;
				case (funct3)
					3'b000:  cmp_op_o = rv_pkg::CMP_EQ;
					3'b001:  cmp_op_o = rv_pkg::CMP_NE;
					3'b100:  cmp_op_o = rv_pkg::CMP_LT;
					3'b101:  cmp_op_o = rv_pkg::CMP_GE;
					3'b110:  cmp_op_o = rv_pkg::CMP_LTU;
					3'b111:  cmp_op_o = rv_pkg::CMP_GEU;
					default: illegal_o = 1'b1;
				endcase
			end
			rv_pkg::OPC_LOAD: begin // address is rs1+imm.
				we_o = 1'b1;
				case (funct3)
					3'b000:  mem_op_o = rv_pkg::MEM_LB;
					3'b001:  mem_op_o = rv_pkg::MEM_LH;
					3'b010:  mem_op_o = rv_pkg::MEM_LW;
					3'b100:  mem_op_o = rv_pkg::MEM_LBU;
					3'b101:  mem_op_o = rv_pkg::MEM_LHU;
					default: illegal_o = 1'b1;
				endcase
			end
			rv_pkg::OPC_STORE: begin
				imm_o = imm_s_type;
				case (funct3)
					3'b000:  mem_op_o = rv_pkg::MEM_SB;
					3'b001:  mem_op_o = rv_pkg::MEM_SH;
					3'b010:  mem_op_o = rv_pkg::MEM_SW;
					default: illegal_o = 1'b1;
				endcase
			end
			rv_pkg::OPC_OP_IMM: begin
				we_o     = 1'b1;
				alu_op_o = f3_alu(funct3, (funct3 == 3'b101) && instr_i[30]);
				if (funct3 == 3'b001 && funct7 != 7'b0000000)
					illegal_o = 1'b1;
				if (funct3 == 3'b101 && {funct7[6], funct7[4:0]} != 6'b000000)
					illegal_o = 1'b1; // only srli and srai.
			end
			rv_pkg::OPC_OP: begin
				we_o      = 1'b1;
				opb_sel_o = rv_pkg::OPB_RS2;
				alu_op_o  = f3_alu(funct3, instr_i[30]);
				if (funct7 == 7'b0100000)
					illegal_o = (funct3 != 3'b000) && (funct3 != 3'b101);
				else if (funct7 != 7'b0000000)
					illegal_o = 1'b1;
			end
			rv_pkg::OPC_SYSTEM: begin
				syscall_o = (instr_i[31:7] == 25'h0000000);
				break_o   = (instr_i[31:7] == 25'h0002000);
				illegal_o = !(syscall_o || break_o); // no csr support.
			end
			default: illegal_o = 1'b1;
		endcase
		if (illegal_o) begin
			we_o     = 1'b0;
			mem_op_o = rv_pkg::MEM_NONE;
		end
	end

	// checked on every new instruction against the settled previous decode.
	a_illegal_no_we: assert property (@(instr_i) !(illegal_o && we_o));

endmodule

// ==== logic/rv_pkg.sv ====
package rv_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// widths and constants
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;
	localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013; // addi x0,x0,0.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// encodings
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011,
		OPC_SYSTEM = 7'b1110011
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND
	} alu_op_e;

	typedef enum logic [2:0] {
		CMP_NONE,
		CMP_EQ,
		CMP_NE,
		CMP_LT,
		CMP_GE,
		CMP_LTU,
		CMP_GEU
	} cmp_op_e;

	typedef enum logic [3:0] {
		MEM_NONE,
		MEM_LB,
		MEM_LH,
		MEM_LW,
		MEM_LBU,
		MEM_LHU,
		MEM_SB,
		MEM_SH,
		MEM_SW
	} mem_op_e;

	// operand selects for the ALU ports.
	typedef enum logic [1:0] {OPA_RS1, OPA_PC, OPA_PC4, OPA_ZERO} opa_sel_e;
	typedef enum logic [1:0] {OPB_RS2, OPB_IMM, OPB_ZERO} opb_sel_e;

	// source of a register operand, driven by the hazard unit.
	typedef enum logic [1:0] {FWD_REG, FWD_EX, FWD_MEM, FWD_WB} fwd_sel_e;

endpackage
